// ==== Bender.yml ====
package:
  name: cpu_control

sources:
  - verilog/isa_pkg.sv
  - verilog/ctrl_pkg.sv
  - verilog/opcode_decoder.sv
  - verilog/cycle_sequencer.sv
  - verilog/step_decoder.sv
  - verilog/interrupt_unit.sv
  - verilog/cpu_control.sv
  - target: test
    files:
      - test/cpu_control_tb.sv

// ==== list.f ====
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/opcode_decoder.sv
verilog/cycle_sequencer.sv
verilog/step_decoder.sv
verilog/interrupt_unit.sv
verilog/cpu_control.sv
test/cpu_control_tb.sv

// ==== test/cpu_control_tb.sv ====
module cpu_control_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_WAIT = 8;  // Longest legal gap between fetches plus slack
    // Worst case of two resets, decode, LD r16, JP, EI/DI, dispatch and halt/stop
    localparam int TEST_CYCLES = 2 * (RESET_CYCLES + 2) + 40 * 4 + 4 * 8 + 20 * 9 + 8 + 12 + 30;
    localparam int MARGIN_CYCLES = 100;

    logic       clk;
    logic       reset;
    opcode_t    opcode_early;
    logic       f_z;
    logic       f_c;
    logic       int_req;
    ctrl_word_t ctrl;
    logic       fetch;
    logic       halt;
    logic       stop;
    logic       int_master_en;
    logic       int_ack;

    cpu_control cpu_control_i (
        .clk           (clk),
        .reset         (reset),
        .opcode_early  (opcode_early),
        .f_z           (f_z),
        .f_c           (f_c),
        .int_req       (int_req),
        .ctrl          (ctrl),
        .fetch         (fetch),
        .halt          (halt),
        .stop          (stop),
        .int_master_en (int_master_en),
        .int_ack       (int_ack)
    );

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired, the tests ran longer than their worst case");
        $display("test failed");
        $fatal(1, "watchdog");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic check(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "aborted");
    endtask

    // Puts op on the bus and returns on the edge that loads it
    task automatic load_opcode(opcode_t op);
        int waited;
        waited = 0;
        @(posedge clk);
        opcode_early <= op;
        @(negedge clk);
        while (!fetch && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch)
            abort("The DUT never reached a fetch cycle to take the opcode");
        @(posedge clk);
        opcode_early <= OP_NOP;  // Filler after op
    endtask

    // Counts cycles up to and including the closing fetch
    task automatic run_to_fetch(output int cycles, output ctrl_word_t first,
                                output ctrl_word_t third);
        cycles = 0;
        first = CTRL_IDLE;
        third = CTRL_IDLE;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles == 1)
                first = ctrl;
            if (cycles == 3)
                third = ctrl;
        end while (!fetch && cycles < MAX_WAIT);
        if (!fetch)
            abort("An instruction never reached its closing fetch");
    endtask

    // LD r,r' or ALU r without an (HL) operand
    function automatic opcode_t random_reg_op();
        logic [1:0] group;
        logic [2:0] upper;
        logic [2:0] lower;
        group = ($urandom % 2) ? 2'b10 : 2'b01;
        do
            upper = 3'($urandom % 8);
        while (group == 2'b01 && upper == 3'd6);
        do
            lower = 3'($urandom % 8);
        while (lower == 3'd6);
        return {group, upper, lower};
    endfunction

    function automatic logic jump_taken(opcode_t op, logic z, logic c);
        case (op)
            OP_JP_NZ: return !z;
            OP_JP_Z:  return z;
            OP_JP_NC: return !c;
            OP_JP_C:  return c;
            default:  return 1'b1;
        endcase
    endfunction

    // Expected word for each slot of an interrupt dispatch
    function automatic ctrl_word_t dispatch_word(int step);
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.next = 1'b1;
        case (step)
            0: w.ct_op = CT_DEC;
            1: begin
                w.bus_op = BUS_WRITE;
                w.ab_src = AB_SP;
                w.db_src = DB_PCH;
                w.ct_op = CT_DEC;
            end
            2: begin
                w.bus_op = BUS_WRITE;
                w.ab_src = AB_SP;
                w.db_src = DB_PCL;
                w.pc_src = PC_SRC_VECTOR;
                w.pc_we = 1'b1;
            end
            default: w = CTRL_FETCH_END;
        endcase
        return w;
    endfunction

    task automatic check_reset_state();
        check("ctrl", ctrl, CTRL_FETCH_END);
        check("fetch", fetch, 1'b1);
        check("halt", halt, 1'b0);
        check("stop", stop, 1'b0);
        check("int_ack", int_ack, 1'b0);
        check("int_master_en", int_master_en, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic test_reset();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);  // This edge samples reset high
            if (i == RESET_CYCLES - 1)
                reset <= 1'b0;
            @(negedge clk);
            check_reset_state();
        end
        @(negedge clk);
        check_reset_state();
    endtask

    task automatic test_decode();
        opcode_t    op;
        ctrl_word_t expected;
        for (int n = 0; n < 40; n++) begin
            op = random_reg_op();
            expected = CTRL_FETCH_END;
            expected.alu_rd_sel = op[2:0];
            if (op[7:6] == 2'b01) begin
                expected.rf_wr_sel = op[5:3];
                expected.rf_wr_en = 1'b1;
            end
            else begin
                expected.alu_op = alu_op_t'(op[5:3]);
                expected.alu_dst = (op[5:3] == 3'd7) ? ALU_DST_NONE : ALU_DST_ACC;  // CP
                expected.flags_we = 1'b1;
            end
            load_opcode(op);
            @(negedge clk);
            check("ctrl", ctrl, expected);
            check("fetch", fetch, 1'b1);
        end
    endtask

    task automatic test_imm_and_jump();
        opcode_t    op;
        ctrl_word_t expected;
        ctrl_word_t first;
        ctrl_word_t third;
        int         cycles;
        logic       taken;
        for (int p = 0; p < 4; p++) begin
            op = {2'b00, 2'(p), 4'h1};
            expected = CTRL_FETCH_END;
            expected.rf_pair_wr = 1'b1;
            expected.pair_sel = 2'(p);
            load_opcode(op);
            run_to_fetch(cycles, first, third);
            check("fetch cycle count", cycles, 3);
            check("ctrl.bus_op", first.bus_op, BUS_READ);
            check("ctrl", third, expected);
        end
        for (int j = 0; j < 5; j++) begin
            case (j)
                0: op = OP_JP;
                1: op = OP_JP_NZ;
                2: op = OP_JP_Z;
                3: op = OP_JP_NC;
                default: op = OP_JP_C;
            endcase
            for (int f = 0; f < 4; f++) begin
                @(posedge clk);
                f_z <= f[0];
                f_c <= f[1];
                taken = jump_taken(op, f[0], f[1]);
                load_opcode(op);
                run_to_fetch(cycles, first, third);
                check("fetch cycle count", cycles, taken ? 4 : 3);
                check("ctrl.pc_we", third.pc_we, taken);
            end
        end
    endtask

    task automatic test_master_enable();
        load_opcode(OP_EI);
        @(negedge clk);
        check("int_master_en", int_master_en, 1'b0);
        @(negedge clk);
        check("int_master_en", int_master_en, 1'b1);
        load_opcode(OP_DI);
        @(negedge clk);
        check("int_master_en", int_master_en, 1'b1);
        @(negedge clk);
        check("int_master_en", int_master_en, 1'b0);
    endtask

    task automatic test_dispatch();
        int waited;
        waited = 0;
        load_opcode(OP_EI);
        @(posedge clk);
        int_req <= 1'b1;
        @(negedge clk);
        while (!fetch && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch)
            abort("No fetch cycle came to start the interrupt dispatch");
        for (int step = 0; step < 4; step++) begin
            @(negedge clk);
            check("ctrl", ctrl, dispatch_word(step));
            check("fetch", fetch, step == 3);
            check("int_ack", int_ack, step == 3);
            check("int_master_en", int_master_en, 1'b1);
        end
        @(posedge clk);
        int_req <= 1'b0;  // Controller saw the ack
        @(negedge clk);
        check("int_master_en", int_master_en, 1'b0);
        check("int_ack", int_ack, 1'b1);
        @(negedge clk);
        check("int_ack", int_ack, 1'b0);
    endtask

    task automatic test_halt_stop();
        int waited;
        waited = 0;
        load_opcode(OP_HALT);
        @(negedge clk);
        check("fetch", fetch, 1'b0);
        repeat (5) begin
            @(negedge clk);
            check("halt", halt, 1'b1);
            check("fetch", fetch, 1'b0);
            check("ctrl", ctrl, CTRL_IDLE);
        end
        @(posedge clk);
        int_req <= 1'b1;  // Wakes the core with the master enable off
        @(negedge clk);
        while (!fetch && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetch)
            abort("HALT did not resume with a fetch after int_req rose");
        check("halt", halt, 1'b0);
        @(posedge clk);
        int_req <= 1'b0;

        load_opcode(8'hD3);  // Undefined opcode
        @(negedge clk);
        check("fetch", fetch, 1'b0);
        @(posedge clk);
        int_req <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check("stop", stop, 1'b1);
            check("fetch", fetch, 1'b0);
            check("ctrl", ctrl, CTRL_IDLE);
        end
        @(posedge clk);
        int_req <= 1'b0;
        test_reset();
    endtask

    initial begin
        void'($urandom(88));
        clk = 1'b0;
        reset = 1'b1;
        opcode_early = OP_NOP;
        f_z = 1'b0;
        f_c = 1'b0;
        int_req = 1'b0;
        test_reset();
        test_decode();
        test_imm_and_jump();
        test_master_enable();
        test_dispatch();
        test_halt_stop();
        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog/cpu_control.sv ====
module cpu_control
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    opcode_early,
    input  logic       f_z,
    input  logic       f_c,
    input  logic       int_req,
    output ctrl_word_t ctrl,
    output logic       fetch,
    output logic       halt,
    output logic       stop,
    output logic       int_master_en,
    output logic       int_ack
);

    ctrl_word_t base;
    opcode_t    opcode;
    logic       supported;
    mcycle_t    m_cycle;
    seq_state_t state;
    logic       dispatch;
    logic       last;
    logic       halt_req;
    logic       stop_req;
    logic       ime_set;
    logic       ime_clear;
    logic       dispatch_done;

    opcode_decoder opcode_decoder_i (
        .clk          (clk),
        .reset        (reset),
        .opcode_early (opcode_early),
        .load         (fetch),
        .opcode       (opcode),
        .base         (base),
        .supported    (supported)
    );

    cycle_sequencer cycle_sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .last     (last),
        .halt_req (halt_req),
        .stop_req (stop_req),
        .int_req  (int_req),
        .m_cycle  (m_cycle),
        .state    (state),
        .fetch    (fetch)
    );

    step_decoder step_decoder_i (
        .m_cycle       (m_cycle),
        .state         (state),
        .opcode        (opcode),
        .base          (base),
        .supported     (supported),
        .dispatch      (dispatch),
        .f_z           (f_z),
        .f_c           (f_c),
        .ctrl          (ctrl),
        .last          (last),
        .halt_req      (halt_req),
        .stop_req      (stop_req),
        .ime_set       (ime_set),
        .ime_clear     (ime_clear),
        .dispatch_done (dispatch_done)
    );

    interrupt_unit interrupt_unit_i (
        .clk           (clk),
        .reset         (reset),
        .int_req       (int_req),
        .fetch         (fetch),
        .ime_set       (ime_set),
        .ime_clear     (ime_clear),
        .dispatch_done (dispatch_done),
        .dispatch      (dispatch),
        .int_master_en (int_master_en),
        .int_ack       (int_ack)
    );

    assign halt = (state == SEQ_HALTED);
    assign stop = (state == SEQ_STOPPED);

endmodule

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;
    import isa_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Control word fields

    typedef enum logic [1:0] {BUS_IDLE, BUS_FETCH, BUS_WRITE, BUS_READ} bus_op_t;
    typedef enum logic [1:0] {AB_PC, AB_TEMP, AB_HL, AB_SP} ab_src_t;
    typedef enum logic [1:0] {DB_ACC, DB_PCH, DB_PCL, DB_RF} db_src_t;
    typedef enum logic [1:0] {CT_NONE, CT_INC, CT_DEC} ct_op_t;
    typedef enum logic [1:0] {PC_SRC_INC, PC_SRC_VECTOR, PC_SRC_TEMP} pc_src_t;
    typedef enum logic [1:0] {ALU_DST_NONE, ALU_DST_ACC, ALU_DST_RF, ALU_DST_PC} alu_dst_t;

    typedef struct packed {
        alu_op_t    alu_op;
        reg8_sel_t  alu_rd_sel;  // ALU operand B
        alu_dst_t   alu_dst;
        logic       rf_wr_en;
        reg8_sel_t  rf_wr_sel;
        logic       rf_pair_wr;  // Load temp into a register pair
        reg16_sel_t pair_sel;
        pc_src_t    pc_src;
        logic       pc_we;
        bus_op_t    bus_op;
        ab_src_t    ab_src;
        db_src_t    db_src;
        ct_op_t     ct_op;       // Address counter
        logic       flags_we;
        logic       next;        // Instruction continues next cycle
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;  // Every enum encodes inactive as 0

    // Closing fetch of every instruction
    localparam ctrl_word_t CTRL_FETCH_END = '{
        alu_op:     ALU_ADD,
        alu_rd_sel: 3'd0,
        alu_dst:    ALU_DST_NONE,
        rf_wr_en:   1'b0,
        rf_wr_sel:  3'd0,
        rf_pair_wr: 1'b0,
        pair_sel:   2'd0,
        pc_src:     PC_SRC_INC,
        pc_we:      1'b0,
        bus_op:     BUS_FETCH,
        ab_src:     AB_PC,
        db_src:     DB_ACC,
        ct_op:      CT_INC,
        flags_we:   1'b0,
        next:       1'b0
    };

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer

    typedef enum logic [1:0] {SEQ_RUN, SEQ_HALTED, SEQ_STOPPED} seq_state_t;

    typedef logic [1:0] mcycle_t;

    localparam mcycle_t MAX_MCYCLE = 2'd3;

endpackage

// ==== verilog/cycle_sequencer.sv ====
module cycle_sequencer
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       last,
    input  logic       halt_req,
    input  logic       stop_req,
    input  logic       int_req,
    output mcycle_t    m_cycle,
    output seq_state_t state,
    output logic       fetch
);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_RUN;
            m_cycle <= '0;
        end
        else begin
            case (state)
                SEQ_RUN: begin
                    m_cycle <= last ? 2'd0 : m_cycle + 2'd1;
                    if (stop_req)
                        state <= SEQ_STOPPED;  // Only reset leaves this
                    else if (halt_req)
                        state <= SEQ_HALTED;
                end
                SEQ_HALTED: begin
                    // m_cycle already points at the resume step
                    if (int_req)
                        state <= SEQ_RUN;
                end
                SEQ_STOPPED: begin
                    state <= SEQ_STOPPED;
                end
                default: begin
                    state <= SEQ_RUN;
                end
            endcase
        end
    end

    assign fetch = (state == SEQ_RUN) && last;

    // Longest instruction closes by m3, the counter never wraps
    assert property (@(posedge clk) disable iff (reset)
        (state == SEQ_RUN && m_cycle == MAX_MCYCLE) |-> last);

endmodule

// ==== verilog/interrupt_unit.sv ====
module interrupt_unit (
    input  logic clk,
    input  logic reset,
    input  logic int_req,
    input  logic fetch,
    input  logic ime_set,
    input  logic ime_clear,
    input  logic dispatch_done,
    output logic dispatch,
    output logic int_master_en,
    output logic int_ack
);

    logic ime;
    logic ack_q;  // Ack held after the dispatch ends

    always_ff @(posedge clk) begin
        if (reset) begin
            ime <= 1'b0;
            dispatch <= 1'b0;
            ack_q <= 1'b0;
        end
        else begin
            if (ime_clear)
                ime <= 1'b0;
            else if (ime_set)
                ime <= 1'b1;
            // Decided at every instruction boundary
            if (fetch)
                dispatch <= int_req && ime && !int_ack;
            ack_q <= int_req && int_ack;  // Drops one cycle after int_req
        end
    end

    assign int_ack = ack_q || dispatch_done;
    assign int_master_en = ime;

    // Four-phase rule, ack only answers a pending request
    assert property (@(posedge clk) disable iff (reset)
        $rose(int_ack) |-> int_req);

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields

    typedef logic [7:0] opcode_t;     // One instruction byte

    // B C D E H L (HL) A, as encoded in the opcode
    typedef logic [2:0] reg8_sel_t;

    typedef logic [1:0] reg16_sel_t;  // BC DE HL SP

    // Same order as opcode bits 5:3 of the ALU group
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    localparam reg8_sel_t REG_HL_MEM = 3'd6;  // Memory operand, no register behind it

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes

    localparam opcode_t OP_NOP          = 8'h00;
    localparam opcode_t OP_HALT         = 8'h76;
    localparam opcode_t OP_DI           = 8'hF3;
    localparam opcode_t OP_EI           = 8'hFB;
    localparam opcode_t OP_JP           = 8'hC3;
    localparam opcode_t OP_JP_NZ        = 8'hC2;
    localparam opcode_t OP_JP_Z         = 8'hCA;
    localparam opcode_t OP_JP_NC        = 8'hD2;
    localparam opcode_t OP_JP_C         = 8'hDA;
    localparam opcode_t LD_R16_IMM_BASE = 8'h01;  // Pair select in bits 5:4
    localparam opcode_t LD_RR_BASE      = 8'h40;
    localparam opcode_t ALU_R_BASE      = 8'h80;

    function automatic logic is_ld_r16_imm(opcode_t op);
        return (op & 8'hCF) == LD_R16_IMM_BASE;
    endfunction

    function automatic logic is_jp(opcode_t op);
        return op inside {OP_JP, OP_JP_NZ, OP_JP_Z, OP_JP_NC, OP_JP_C};
    endfunction

endpackage

// ==== verilog/opcode_decoder.sv ====
module opcode_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    opcode_early,
    input  logic       load,
    output opcode_t    opcode,
    output ctrl_word_t base,
    output logic       supported
);

    ctrl_word_t base_d;
    logic       supported_d;

    // First-cycle word straight from the opcode bits
    always_comb begin
        base_d = CTRL_FETCH_END;  // Single-cycle ops close with the fetch
        supported_d = 1'b1;
        if (opcode_early == OP_HALT) begin
            base_d = CTRL_IDLE;
            base_d.next = 1'b1;  // Resume cycle does the fetch
        end
        else if ((opcode_early & 8'hC0) == LD_RR_BASE) begin
            base_d.rf_wr_sel = opcode_early[5:3];
            base_d.alu_rd_sel = opcode_early[2:0];
            base_d.rf_wr_en = 1'b1;
            if (opcode_early[5:3] == REG_HL_MEM || opcode_early[2:0] == REG_HL_MEM)
                supported_d = 1'b0;
        end
        else if ((opcode_early & 8'hC0) == ALU_R_BASE) begin
            base_d.alu_op = alu_op_t'(opcode_early[5:3]);
            base_d.alu_rd_sel = opcode_early[2:0];
            base_d.flags_we = 1'b1;
            // CP only updates flags
            base_d.alu_dst = (opcode_early[5:3] == ALU_CP) ? ALU_DST_NONE : ALU_DST_ACC;
            if (opcode_early[2:0] == REG_HL_MEM)
                supported_d = 1'b0;
        end
        else if (is_ld_r16_imm(opcode_early) || is_jp(opcode_early)) begin
            // Low immediate byte
            base_d = CTRL_IDLE;
            base_d.bus_op = BUS_READ;
            base_d.ab_src = AB_PC;
            base_d.ct_op = CT_INC;
            base_d.next = 1'b1;
        end
        else if (!(opcode_early inside {OP_NOP, OP_DI, OP_EI})) begin
            supported_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode <= OP_NOP;  // Gives a fetch right after reset
            base <= CTRL_FETCH_END;
            supported <= 1'b1;
        end
        else if (load) begin
            opcode <= opcode_early;
            base <= base_d;
            supported <= supported_d;
        end
    end

    // (HL) operands have no datapath path here
    assert property (@(posedge clk) disable iff (reset)
        supported |-> (base.alu_rd_sel != REG_HL_MEM && base.rf_wr_sel != REG_HL_MEM));

endmodule

// ==== verilog/step_decoder.sv ====
module step_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  mcycle_t    m_cycle,
    input  seq_state_t state,
    input  opcode_t    opcode,
    input  ctrl_word_t base,
    input  logic       supported,
    input  logic       dispatch,
    input  logic       f_z,
    input  logic       f_c,
    output ctrl_word_t ctrl,
    output logic       last,
    output logic       halt_req,
    output logic       stop_req,
    output logic       ime_set,
    output logic       ime_clear,
    output logic       dispatch_done
);

    logic cond_met;
    logic jp_taken;

    always_comb begin
        case (opcode[4:3])  // NZ Z NC C
            2'b00:   cond_met = !f_z;
            2'b01:   cond_met = f_z;
            2'b10:   cond_met = !f_c;
            default: cond_met = f_c;
        endcase
        jp_taken = (opcode == OP_JP) || cond_met;
    end

    always_comb begin
        ctrl = base;
        halt_req = 1'b0;
        stop_req = 1'b0;
        ime_set = 1'b0;
        ime_clear = 1'b0;
        dispatch_done = 1'b0;
        if (state != SEQ_RUN) begin
            ctrl = CTRL_IDLE;
        end
        ////////////////////////////////////////////////////////////////////////
        // Interrupt dispatch, the sampled opcode is ignored
        else if (dispatch) begin
            ctrl = CTRL_IDLE;  // ALU and flags nullified throughout
            ctrl.next = 1'b1;
            case (m_cycle)
                2'd0: ctrl.ct_op = CT_DEC;
                2'd1: begin
                    ctrl.bus_op = BUS_WRITE;  // Push PC high
                    ctrl.ab_src = AB_SP;
                    ctrl.db_src = DB_PCH;
                    ctrl.ct_op = CT_DEC;
                end
                2'd2: begin
                    ctrl.bus_op = BUS_WRITE;  // Push PC low
                    ctrl.ab_src = AB_SP;
                    ctrl.db_src = DB_PCL;
                    ctrl.pc_src = PC_SRC_VECTOR;
                    ctrl.pc_we = 1'b1;
                end
                default: begin
                    ctrl = CTRL_FETCH_END;
                    ime_clear = 1'b1;
                    dispatch_done = 1'b1;
                end
            endcase
        end
        else if (!supported) begin
            ctrl = CTRL_IDLE;
            ctrl.next = 1'b1;  // Keep fetch low on the way to STOPPED
            stop_req = 1'b1;
        end
        ////////////////////////////////////////////////////////////////////////
        // Later machine cycles
        else begin
            case (m_cycle)
                2'd0: begin
                    halt_req = (opcode == OP_HALT);
                    ime_clear = (opcode == OP_DI);
                    ime_set = (opcode == OP_EI);
                end
                2'd1: begin
                    // High immediate byte, base already reads through PC
                    if (!(is_ld_r16_imm(opcode) || is_jp(opcode)))
                        ctrl = CTRL_FETCH_END;  // HALT resume lands here
                end
                2'd2: begin
                    ctrl = CTRL_FETCH_END;
                    if (is_ld_r16_imm(opcode)) begin
                        ctrl.rf_pair_wr = 1'b1;
                        ctrl.pair_sel = opcode[5:4];
                    end
                    else if (is_jp(opcode) && jp_taken) begin
                        ctrl = CTRL_IDLE;
                        ctrl.pc_src = PC_SRC_TEMP;
                        ctrl.pc_we = 1'b1;
                        ctrl.next = 1'b1;
                    end
                end
                default: ctrl = CTRL_FETCH_END;
            endcase
        end
    end

    assign last = !ctrl.next;

endmodule
